//--- testbench/rgb_led_model.svh
`ifndef RGB_LED_MODEL_SVH
`define RGB_LED_MODEL_SVH

// Three channels packed as {red, green, blue}
typedef logic [3*`COLOR_WIDTH-1:0] rgb_word_t;

// Linear RGB from HSL, 4095 standing for 1.0 throughout
function automatic rgb_word_t model_hsl(input color_t h, input color_t s, input color_t l);
  logic [31:0] two_l;
  logic [31:0] spread;
  logic [31:0] h6;
  logic [31:0] h_rem;
  logic [31:0] h_dist;
  logic [31:0] c;
  logic [31:0] x;
  logic [31:0] m;
  color_t      mc;
  color_t      mx;
  color_t      mo;
  hue_sector_t sector;
  two_l  = 32'(l) * 2;
  // |2L - 1|
  spread = (two_l >= `COLOR_MAX) ? two_l - `COLOR_MAX : `COLOR_MAX - two_l;
  c      = ((`COLOR_MAX - spread) * 32'(s)) >> `COLOR_WIDTH;
  h6     = 32'(h) * 6;
  sector = hue_sector_t'(h6[`COLOR_WIDTH +: 3]);
  h_rem  = h6 % `HUE_MOD;
  h_dist = (h_rem >= `COLOR_MAX) ? h_rem - `COLOR_MAX : `COLOR_MAX - h_rem;
  x      = (c * (`COLOR_MAX - h_dist)) >> `COLOR_WIDTH;
  m      = 32'(l) - (c >> 1);
  mc     = color_t'(m + c);
  mx     = color_t'(m + x);
  mo     = color_t'(m);
  case (sector)
    sector_red_yellow:   return {mc, mx, mo};
    sector_yellow_green: return {mx, mc, mo};
    sector_green_cyan:   return {mo, mc, mx};
    sector_cyan_blue:    return {mo, mx, mc};
    sector_blue_magenta: return {mx, mo, mc};
    sector_magenta_red:  return {mc, mo, mx};
    default:             return {mo, mo, mo};
  endcase
endfunction

// Piecewise-linear gamma between the knees of the table
function automatic color_t model_gamma(input color_t v);
  int seg;
  int frac;
  int rise;
  seg  = int'(v) >> gamma_seg_shift_c;
  frac = int'(v) % (1 << gamma_seg_shift_c);
  // Upper half of a segment counts one step more, so its top code hits the next knee
  if (frac >= (1 << (gamma_seg_shift_c - 1))) begin
    frac = frac + 1;
  end
  rise = int'(gamma_knee_c[seg + 1]) - int'(gamma_knee_c[seg]);
  return color_t'(int'(gamma_knee_c[seg]) + ((rise * frac) >> gamma_seg_shift_c));
endfunction

`endif

//--- testbench/rgb_led_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "led_color_config.svh"

module rgb_led_tb
  import color_types_pkg::*, gamma_lut_pkg::*;
();

  localparam int clk_period_ns = 40;
  localparam int pwm_period    = 1 << `PWM_WIDTH;
  // 200 conversions of 8 cycles plus 3 PWM periods plus margin for the short tests
  localparam int watchdog_cycles = 200 * 8 + 3 * pwm_period + 2000;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   valid_hue;
  color_t hue;
  color_t saturation;
  color_t lightness;
  logic   ready;
  logic   valid_rgb;
  color_t color_red;
  color_t color_green;
  color_t color_blue;
  logic   led_red;
  logic   led_green;
  logic   led_blue;

  int     seed;
  string  cur_test;
  int     test_errors;
  int     pass_count;
  int     fail_count;

  `include "rgb_led_model.svh"

  rgb_led_top rgb_led_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_hue   (valid_hue),
    .hue         (hue),
    .saturation  (saturation),
    .lightness   (lightness),
    .ready       (ready),
    .valid_rgb   (valid_rgb),
    .color_red   (color_red),
    .color_green (color_green),
    .color_blue  (color_blue),
    .led_red     (led_red),
    .led_green   (led_green),
    .led_blue    (led_blue)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("%s: PASS", cur_test);
      pass_count++;
    end else begin
      $display("%s: FAIL with %0d errors", cur_test, test_errors);
      fail_count++;
    end
  endtask

  task automatic check_color(input string name, input color_t expected, input color_t actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d, actual %0d", cur_test, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %b, actual %b", cur_test, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("ERROR %s %s: expected %0d, actual %0d", cur_test, name, expected, actual);
      test_errors++;
    end
  endtask

  // Result and LED outputs all low
  task automatic check_outputs_zero();
    check_bit("valid_rgb", 1'b0, valid_rgb);
    check_color("color_red", '0, color_red);
    check_color("color_green", '0, color_green);
    check_color("color_blue", '0, color_blue);
    check_bit("led_red", 1'b0, led_red);
    check_bit("led_green", 1'b0, led_green);
    check_bit("led_blue", 1'b0, led_blue);
  endtask

  // Expected corrected colour for one HSL triple against the DUT result
  task automatic check_result(input color_t h, input color_t s, input color_t l,
                              input color_t r, input color_t g, input color_t b);
    rgb_word_t lin;
    lin = model_hsl(h, s, l);
    check_color("red", model_gamma(lin[2*`COLOR_WIDTH +: `COLOR_WIDTH]), r);
    check_color("green", model_gamma(lin[`COLOR_WIDTH +: `COLOR_WIDTH]), g);
    check_color("blue", model_gamma(lin[0 +: `COLOR_WIDTH]), b);
  endtask

  // Offers one triple and waits for valid_rgb
  // An optional strobe of valid_hue with new inputs falls in the busy window
  task automatic run_conversion(input color_t h, input color_t s, input color_t l,
                                input bit strobe_busy,
                                output color_t r, output color_t g, output color_t b,
                                output int latency, output int ready_low);
    int n;
    int guard;
    r         = '0;
    g         = '0;
    b         = '0;
    latency   = -1;
    ready_low = 0;
    guard     = 0;
    @(negedge clk);
    while (ready !== 1'b1 && guard < 20) begin
      @(negedge clk);
      guard++;
    end
    if (ready !== 1'b1) begin
      $display("%s: ready never went high, conversion not started", cur_test);
      test_errors++;
    end else begin
      @(posedge clk);
      valid_hue  <= 1'b1;
      hue        <= h;
      saturation <= s;
      lightness  <= l;
      // Accepting edge
      @(posedge clk);
      valid_hue <= 1'b0;
      n = 0;
      @(negedge clk);
      if (ready === 1'b0) begin
        ready_low++;
      end
      while (latency < 0 && n < 20) begin
        @(posedge clk);
        n++;
        if (strobe_busy && n == 1) begin
          valid_hue  <= 1'b1;
          hue        <= ~h;
          saturation <= ~s;
          lightness  <= ~l;
        end
        if (strobe_busy && n == 3) begin
          valid_hue <= 1'b0;
        end
        @(negedge clk);
        if (n <= 5 && ready === 1'b0) begin
          ready_low++;
        end
        if (valid_rgb === 1'b1) begin
          latency = n;
          r       = color_red;
          g       = color_green;
          b       = color_blue;
        end
      end
      if (latency < 0) begin
        $display("%s: no valid_rgb within 20 cycles after acceptance", cur_test);
        test_errors++;
      end
    end
  endtask

  task automatic count_led_high(input int cycles, output int n_r, output int n_g,
                                output int n_b);
    n_r = 0;
    n_g = 0;
    n_b = 0;
    repeat (cycles) begin
      @(negedge clk);
      n_r += int'(led_red === 1'b1);
      n_g += int'(led_green === 1'b1);
      n_b += int'(led_blue === 1'b1);
    end
  endtask

  // Watchdog
  initial begin
    hsl_state_t st;
    #(watchdog_cycles * clk_period_ns);
    st = rgb_led_top_i.hsl_to_rgb_i.state;
    $display("Run timed out after %0d cycles with the converter in state %s",
             watchdog_cycles, st.name());
    $display("test failed");
    $finish;
  end

  initial begin
    color_t h;
    color_t s;
    color_t l;
    color_t r;
    color_t g;
    color_t b;
    int     lat;
    int     rlow;
    int     extra;
    int     n_r;
    int     n_g;
    int     n_b;
    rgb_word_t lin;
    rst_n      = 1'b0;
    valid_hue  = 1'b0;
    hue        = '0;
    saturation = '0;
    lightness  = '0;
    seed       = 32'h24d3;
    pass_count = 0;
    fail_count = 0;

    begin_test("reset");
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_bit("ready in reset", 1'b0, ready);
    check_outputs_zero();
    @(posedge clk);
    rst_n <= 1'b1;
    // First active edge comes between these two falling edges
    @(negedge clk);
    @(negedge clk);
    check_bit("ready after release", 1'b1, ready);
    check_outputs_zero();
    end_test();

    begin_test("conversion");
    for (int i = 0; i < 200; i++) begin
      h = color_t'($random(seed));
      s = color_t'($random(seed));
      l = color_t'($random(seed));
      // One hue in each sector and then the corner hues and lightness values
      if (i < 6) begin
        h = color_t'(i * 683 + 200);
      end else if (i == 6) begin
        h = '0;
      end else if (i == 7) begin
        h = `COLOR_MAX;
      end
      if (i == 8) begin
        l = '0;
      end else if (i == 9) begin
        l = 2047;
      end else if (i == 10) begin
        l = `COLOR_MAX;
      end
      run_conversion(h, s, l, 1'b0, r, g, b, lat, rlow);
      check_result(h, s, l, r, g, b);
    end
    end_test();

    begin_test("latency and busy");
    for (int i = 0; i < 6; i++) begin
      h = color_t'($random(seed));
      s = color_t'($random(seed));
      l = color_t'($random(seed));
      run_conversion(h, s, l, (i % 2 == 1), r, g, b, lat, rlow);
      check_count("latency", 6, lat);
      check_count("ready low cycles", 4, rlow);
      check_result(h, s, l, r, g, b);
      extra = 0;
      repeat (12) begin
        @(negedge clk);
        extra += int'(valid_rgb === 1'b1);
      end
      check_count("extra valid_rgb", 0, extra);
    end
    end_test();

    begin_test("gamma knees");
    // Zero saturation makes every linear channel equal to the lightness
    for (int k = 0; k < `GAMMA_KNEES; k++) begin
      l = (k == `GAMMA_KNEES - 1) ? color_t'(`COLOR_MAX) : color_t'(k << gamma_seg_shift_c);
      run_conversion(color_t'($random(seed)), '0, l, 1'b0, r, g, b, lat, rlow);
      check_color("red", gamma_knee_c[k], r);
      check_color("green", gamma_knee_c[k], g);
      check_color("blue", gamma_knee_c[k], b);
    end
    run_conversion(color_t'($random(seed)), `COLOR_MAX, '0, 1'b0, r, g, b, lat, rlow);
    check_color("black red", '0, r);
    check_color("black green", '0, g);
    check_color("black blue", '0, b);
    end_test();

    begin_test("pwm");
    h = color_t'($random(seed));
    s = color_t'($random(seed));
    l = color_t'($random(seed));
    run_conversion(h, s, l, 1'b0, r, g, b, lat, rlow);
    check_result(h, s, l, r, g, b);
    lin = model_hsl(h, s, l);
    repeat (2 * pwm_period) @(posedge clk);
    count_led_high(pwm_period, n_r, n_g, n_b);
    check_count("led_red high cycles",
                int'(model_gamma(lin[2*`COLOR_WIDTH +: `COLOR_WIDTH])), n_r);
    check_count("led_green high cycles",
                int'(model_gamma(lin[`COLOR_WIDTH +: `COLOR_WIDTH])), n_g);
    check_count("led_blue high cycles",
                int'(model_gamma(lin[0 +: `COLOR_WIDTH])), n_b);
    end_test();

    $display("Summary: %0d tests ok, %0d tests failing", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/color_types_pkg.sv
`default_nettype none

`include "led_color_config.svh"

package color_types_pkg;

  // One colour channel or one HSL component
  typedef logic [`COLOR_WIDTH-1:0] color_t;

  // Converter steps, one per clock
  typedef enum logic [2:0] {
    calculate_chroma,
    calculate_x0,
    calculate_x1,
    set_hue,
    output_rgb
  } hsl_state_t;

  // 60 degree hue sectors, in H' order
  typedef enum logic [2:0] {
    sector_red_yellow,
    sector_yellow_green,
    sector_green_cyan,
    sector_cyan_blue,
    sector_blue_magenta,
    sector_magenta_red
  } hue_sector_t;

endpackage

`default_nettype wire

//--- verilog/gamma_correct.sv
`default_nettype none
`timescale 1ns/1ps

`include "led_color_config.svh"

module gamma_correct
  import color_types_pkg::*, gamma_lut_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,

  input  wire    lin_valid,
  input  wire color_t lin_red,
  input  wire color_t lin_green,
  input  wire color_t lin_blue,

  output logic   valid_rgb,
  output color_t color_red,
  output color_t color_green,
  output color_t color_blue
);

  localparam int ch_n   = 3;
  localparam int idx_w  = $clog2(`GAMMA_KNEES - 1);
  // One extra bit so the fraction can reach a full segment
  localparam int frac_w = gamma_seg_shift_c + 1;

  color_t lin_ch [ch_n];
  color_t color_ch [ch_n];
  logic   valid_q;

  assign lin_ch[0] = lin_red;
  assign lin_ch[1] = lin_green;
  assign lin_ch[2] = lin_blue;

  for (genvar i = 0; i < ch_n; i++) begin : g_ch
    logic [idx_w-1:0]             seg;
    logic [idx_w:0]               seg_next;
    logic [gamma_seg_shift_c-1:0] frac;
    logic [frac_w-1:0]            frac_ext;
    color_t                       knee_q;
    color_t                       diff_q;
    logic [frac_w-1:0]            frac_q;
    logic [`COLOR_WIDTH+frac_w-1:0] prod;
    color_t                       out_q;

    assign seg      = lin_ch[i][`COLOR_WIDTH-1 -: idx_w];
    assign seg_next = {1'b0, seg} + 1'b1;
    assign frac     = lin_ch[i][gamma_seg_shift_c-1:0];
    // Map 0..255 onto 0..256 so the top code lands on the next knee
    assign frac_ext = {1'b0, frac} + frac_w'(frac[gamma_seg_shift_c-1]);

    // Stage one: knee, slope to next knee, fraction
    always_ff @(posedge clk) begin
      knee_q <= gamma_knee_c[seg];
      diff_q <= gamma_knee_c[seg_next] - gamma_knee_c[seg];
      frac_q <= frac_ext;
    end

    assign prod = diff_q * frac_q;

    // Stage two: interpolated value
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        out_q <= '0;
      end else if (valid_q) begin
        out_q <= knee_q + color_t'(prod >> gamma_seg_shift_c);
      end
    end

    assign color_ch[i] = out_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      valid_rgb <= 1'b0;
    end else begin
      valid_q   <= lin_valid;
      valid_rgb <= valid_q;
    end
  end

  assign color_red   = color_ch[0];
  assign color_green = color_ch[1];
  assign color_blue  = color_ch[2];

endmodule

`default_nettype wire

//--- verilog/gamma_lut_pkg.sv
`default_nettype none

`include "led_color_config.svh"

package gamma_lut_pkg;

  import color_types_pkg::*;

  // Low input bits that form the interpolation fraction
  parameter int gamma_seg_shift_c = 8;

  // Knees of a 2.2 power curve at every 256th linear code
  // Entry k is round(4095 * (k/16)^2.2)
  parameter color_t gamma_knee_c [`GAMMA_KNEES] = '{
    12'd0,
    12'd9,
    12'd42,
    12'd103,
    12'd194,
    12'd317,
    12'd473,
    12'd664,
    12'd891,
    12'd1155,
    12'd1456,
    12'd1796,
    12'd2175,
    12'd2593,
    12'd3052,
    12'd3553,
    12'd4095
  };

endpackage

`default_nettype wire

//--- verilog/hsl_to_rgb.sv
`default_nettype none
`timescale 1ns/1ps

`include "led_color_config.svh"

module hsl_to_rgb
  import color_types_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,

  input  wire    valid_hue,
  input  wire color_t hue,
  input  wire color_t saturation,
  input  wire color_t lightness,

  output logic   ready,

  output logic   lin_valid,
  output color_t lin_red,
  output color_t lin_green,
  output color_t lin_blue
);

  localparam logic [31:0] max_c     = 32'(`COLOR_MAX);
  localparam logic [31:0] hue_mod_c = 32'(`HUE_MOD);

  hsl_state_t  state;
  logic        accept;

  // Captured inputs
  color_t      sat_q;
  color_t      light_q;

  // Step 1 results
  logic [31:0] light_x2;
  logic [31:0] chroma_light;
  logic [31:0] hue_scaled;

  // Step 2 results
  logic [2:0]  sector_sel;
  logic [31:0] hue_mod;
  hue_sector_t hue_sector;
  logic [31:0] chroma;
  logic [31:0] x0;

  // Step 3 results
  logic [31:0] x1;
  logic [31:0] m_light;

  // Step 4 results
  color_t      m_plus_c;
  color_t      m_plus_x;
  color_t      m_only;
  color_t      red_q;
  color_t      green_q;
  color_t      blue_q;

  assign accept   = ready && valid_hue;
  assign light_x2 = 32'(lightness) << 1;

  // H' = 6H / 4096, at most 5 for H = 4095
  assign sector_sel = hue_scaled[`COLOR_WIDTH +: 3];
  assign hue_mod    = hue_scaled % hue_mod_c;

  // Channel candidates, truncated to the colour width
  assign m_plus_c = color_t'(m_light + chroma);
  assign m_plus_x = color_t'(m_light + x1);
  assign m_only   = color_t'(m_light);

  // Sequencing, handshake and result registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= calculate_chroma;
      ready     <= 1'b0;
      lin_valid <= 1'b0;
      lin_red   <= '0;
      lin_green <= '0;
      lin_blue  <= '0;
    end else begin
      lin_valid <= 1'b0;
      case (state)
        calculate_chroma: begin
          ready <= 1'b1;
          if (accept) begin
            state <= calculate_x0;
            ready <= 1'b0;
          end
        end
        calculate_x0: begin
          state <= calculate_x1;
        end
        calculate_x1: begin
          state <= set_hue;
        end
        set_hue: begin
          state <= output_rgb;
        end
        output_rgb: begin
          state     <= calculate_chroma;
          ready     <= 1'b1;
          lin_valid <= 1'b1;
          lin_red   <= red_q;
          lin_green <= green_q;
          lin_blue  <= blue_q;
        end
        default: begin
          state <= calculate_chroma;
          ready <= 1'b0;
        end
      endcase
    end
  end

  // Arithmetic, one step per state
  always_ff @(posedge clk) begin
    case (state)
      calculate_chroma: begin
        if (accept) begin
          sat_q   <= saturation;
          light_q <= lightness;
          // |2L - 1| in 12-bit scaling
          if (light_x2 >= max_c) begin
            chroma_light <= light_x2 - max_c;
          end else begin
            chroma_light <= max_c - light_x2;
          end
          hue_scaled <= 32'(hue) * 32'd6;
        end
      end
      calculate_x0: begin
        hue_sector <= hue_sector_t'(sector_sel);
        // C = (1 - |2L - 1|) * S
        chroma <= ((max_c - chroma_light) * 32'(sat_q)) >> `COLOR_WIDTH;
        // |(H' mod 2) - 1|
        if (hue_mod >= max_c) begin
          x0 <= hue_mod - max_c;
        end else begin
          x0 <= max_c - hue_mod;
        end
      end
      calculate_x1: begin
        // X = C * (1 - |(H' mod 2) - 1|)
        x1 <= (chroma * (max_c - x0)) >> `COLOR_WIDTH;
        // m = L - C/2
        m_light <= 32'(light_q) - (chroma >> 1);
      end
      set_hue: begin
        case (hue_sector)
          sector_red_yellow: begin
            red_q   <= m_plus_c;
            green_q <= m_plus_x;
            blue_q  <= m_only;
          end
          sector_yellow_green: begin
            red_q   <= m_plus_x;
            green_q <= m_plus_c;
            blue_q  <= m_only;
          end
          sector_green_cyan: begin
            red_q   <= m_only;
            green_q <= m_plus_c;
            blue_q  <= m_plus_x;
          end
          sector_cyan_blue: begin
            red_q   <= m_only;
            green_q <= m_plus_x;
            blue_q  <= m_plus_c;
          end
          sector_blue_magenta: begin
            red_q   <= m_plus_x;
            green_q <= m_only;
            blue_q  <= m_plus_c;
          end
          sector_magenta_red: begin
            red_q   <= m_plus_c;
            green_q <= m_only;
            blue_q  <= m_plus_x;
          end
          default: begin
            // Unreachable sector codes give grey
            red_q   <= m_only;
            green_q <= m_only;
            blue_q  <= m_only;
          end
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/led_color_config.svh
`ifndef LED_COLOR_CONFIG_SVH
`define LED_COLOR_CONFIG_SVH

// Bits per colour channel and per HSL component
`define COLOR_WIDTH 12

// Largest colour value, also the fixed-point 1.0
`define COLOR_MAX 4095

// Modulus for the H' mod 2 term in 12-bit scaling
`define HUE_MOD 8191

// Gamma breakpoints, 16 segments of 256 codes
`define GAMMA_KNEES 17

// PWM period counter width
`define PWM_WIDTH 12

`endif

//--- verilog/pwm_rgb.sv
`default_nettype none
`timescale 1ns/1ps

`include "led_color_config.svh"

module pwm_rgb
  import color_types_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,

  input  wire    valid_rgb,
  input  wire color_t color_red,
  input  wire color_t color_green,
  input  wire color_t color_blue,

  output logic   led_red,
  output logic   led_green,
  output logic   led_blue
);

  localparam int ch_n = 3;

  logic [`PWM_WIDTH-1:0] period_cnt;
  logic                  period_end;

  color_t                duty_in [ch_n];
  color_t                duty_pend [ch_n];
  color_t                duty_act [ch_n];
  logic [ch_n-1:0]       led_q;

  assign duty_in[0] = color_red;
  assign duty_in[1] = color_green;
  assign duty_in[2] = color_blue;

  // Last count of the period, active duty reloads here
  assign period_end = (period_cnt == '1);

  // Free-running period counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // Pending set follows each result, active set changes only at wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ch_n; i++) begin
        duty_pend[i] <= '0;
        duty_act[i]  <= '0;
      end
      led_q <= '0;
    end else begin
      for (int i = 0; i < ch_n; i++) begin
        if (valid_rgb) begin
          duty_pend[i] <= duty_in[i];
        end
        if (period_end) begin
          duty_act[i] <= duty_pend[i];
        end
        // High for duty counts out of every 4096
        led_q[i] <= (period_cnt < duty_act[i]);
      end
    end
  end

  assign led_red   = led_q[0];
  assign led_green = led_q[1];
  assign led_blue  = led_q[2];

endmodule

`default_nettype wire

//--- verilog/rgb_led_top.sv
`default_nettype none
`timescale 1ns/1ps

module rgb_led_top
  import color_types_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,

  input  wire    valid_hue,
  input  wire color_t hue,
  input  wire color_t saturation,
  input  wire color_t lightness,

  output logic   ready,

  output logic   valid_rgb,
  output color_t color_red,
  output color_t color_green,
  output color_t color_blue,

  output logic   led_red,
  output logic   led_green,
  output logic   led_blue
);

  // Linear RGB between converter and gamma stage
  logic   lin_valid;
  color_t lin_red;
  color_t lin_green;
  color_t lin_blue;

  hsl_to_rgb hsl_to_rgb_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_hue  (valid_hue),
    .hue        (hue),
    .saturation (saturation),
    .lightness  (lightness),
    .ready      (ready),
    .lin_valid  (lin_valid),
    .lin_red    (lin_red),
    .lin_green  (lin_green),
    .lin_blue   (lin_blue)
  );

  gamma_correct gamma_correct_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .lin_valid   (lin_valid),
    .lin_red     (lin_red),
    .lin_green   (lin_green),
    .lin_blue    (lin_blue),
    .valid_rgb   (valid_rgb),
    .color_red   (color_red),
    .color_green (color_green),
    .color_blue  (color_blue)
  );

  pwm_rgb pwm_rgb_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_rgb   (valid_rgb),
    .color_red   (color_red),
    .color_green (color_green),
    .color_blue  (color_blue),
    .led_red     (led_red),
    .led_green   (led_green),
    .led_blue    (led_blue)
  );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
+incdir+testbench
verilog/color_types_pkg.sv
verilog/gamma_lut_pkg.sv
verilog/hsl_to_rgb.sv
verilog/gamma_correct.sv
verilog/pwm_rgb.sv
verilog/rgb_led_top.sv
testbench/rgb_led_tb.sv
